// ==== source/bp_pkg.sv ====
package bp_pkg;

    // ------------------------------
    // Widths and table geometry
    // ------------------------------

    // Word address of a fetched instruction
    localparam int ADDR_WIDTH = 29;

    // Global and chooser tables hold 2^GH_WIDTH counters each
    localparam int GH_WIDTH   = 10;

    // Bimodal index width, also the length of one local history
    localparam int BH_WIDTH   = 10;

    // Low pc bits that pick one of the local history entries
    localparam int LHT_BITS   = 6;

    localparam int NUM_BANKS  = 3;

    // Bank positions inside the generate loop of the top level
    localparam int BANK_BIM   = 0;
    localparam int BANK_GLB   = 1;
    localparam int BANK_CHO   = 2;

    // ------------------------------
    // Plain vector types
    // ------------------------------

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [GH_WIDTH-1:0]   pht_idx_t;
    typedef logic [1:0]            ctr_t;

    // Counter encodings, MSB is the predicted direction
    localparam ctr_t CTR_STRONG_LOW  = 2'b00;
    localparam ctr_t CTR_WEAK_LOW    = 2'b01;
    localparam ctr_t CTR_STRONG_HIGH = 2'b11;

    // Branch kind found by predecode or by execute
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        CALL          = 3'd2,
        RET           = 3'd3,
        INDIRECT_JUMP = 3'd4,
        OTHER_JUMP    = 3'd5
    } br_kind_e;

    // ------------------------------
    // Bundles
    // ------------------------------

    typedef struct packed {
        addr_t    pc;
        br_kind_e kind;
    } pdc_query_t;

    typedef struct packed {
        addr_t    pc;
        br_kind_e kind;
        logic     taken_real;
        logic     choice_real;
    } ex_resolve_t;

    typedef pht_idx_t [NUM_BANKS-1:0] bank_idx_t;
    typedef logic [NUM_BANKS-1:0]     bank_bit_t;

endpackage

// ==== source/history_hash.sv ====
`timescale 1ns/1ps

module history_hash (
    input  logic              clk,
    input  logic              rst_n,
    input  bp_pkg::addr_t     query_pc,
    input  bp_pkg::addr_t     resolve_pc,
    input  logic              train_en,
    input  logic              taken_real,
    output bp_pkg::bank_idx_t rd_idx,
    output bp_pkg::bank_idx_t wr_idx
);
    import bp_pkg::*;

    // Global history register, newest outcome in bit 0
    logic [GH_WIDTH-1:0] ghr;

    // Local history table, one shift register per pc slot
    logic [BH_WIDTH-1:0] lht [2**LHT_BITS];

    logic [LHT_BITS-1:0] query_lht_sel;
    logic [LHT_BITS-1:0] resolve_lht_sel;
    logic [BH_WIDTH-1:0] query_local;
    logic [BH_WIDTH-1:0] resolve_local;

    // Fold a history into the low pc bits
    function automatic pht_idx_t hash_pc(input addr_t pc, input pht_idx_t hist);
        return pc[GH_WIDTH-1:0] ^ hist;
    endfunction

    // ------------------------------
    // Local history lookup
    // ------------------------------

    assign query_lht_sel   = query_pc[LHT_BITS-1:0];
    assign resolve_lht_sel = resolve_pc[LHT_BITS-1:0];

    assign query_local   = lht[query_lht_sel];
    assign resolve_local = lht[resolve_lht_sel];

    // ------------------------------
    // Index forming
    // ------------------------------

    // Query side, state before any training in this cycle
    always_comb begin
        rd_idx           = '0;
        rd_idx[BANK_BIM] = hash_pc(query_pc, query_local);
        rd_idx[BANK_GLB] = hash_pc(query_pc, ghr);
        rd_idx[BANK_CHO] = hash_pc(query_pc, ghr);
    end

    // Resolve side uses the same histories, so the entry that was read
    // for this branch is the one that gets trained
    always_comb begin
        wr_idx           = '0;
        wr_idx[BANK_BIM] = hash_pc(resolve_pc, resolve_local);
        wr_idx[BANK_GLB] = hash_pc(resolve_pc, ghr);
        wr_idx[BANK_CHO] = hash_pc(resolve_pc, ghr);
    end

    // ------------------------------
    // History update
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (train_en) begin
            ghr <= {ghr[GH_WIDTH-2:0], taken_real};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**LHT_BITS; i++) begin
                lht[i] <= '0;
            end
        end else if (train_en) begin
            lht[resolve_lht_sel] <= {resolve_local[BH_WIDTH-2:0], taken_real};
        end
    end

endmodule

// ==== source/pht_bank.sv ====
`timescale 1ns/1ps

module pht_bank (
    input  logic             clk,
    input  logic             rst_n,
    input  bp_pkg::pht_idx_t rd_idx,
    input  bp_pkg::pht_idx_t wr_idx,
    input  logic             train_en,
    input  logic             train_bit,
    output logic             rd_bit
);
    import bp_pkg::*;

    // One two-bit counter per index
    ctr_t ctr_mem [2**GH_WIDTH];

    ctr_t wr_ctr;
    ctr_t wr_ctr_next;

    // ------------------------------
    // Read port
    // ------------------------------

    // Direction is the counter MSB
    assign rd_bit = ctr_mem[rd_idx][1];

    // ------------------------------
    // Training port
    // ------------------------------

    assign wr_ctr = ctr_mem[wr_idx];

    // Step one toward the training bit, hold at either end
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (train_bit) begin
            if (wr_ctr != CTR_STRONG_HIGH) begin
                wr_ctr_next = wr_ctr + 2'd1;
            end
        end else begin
            if (wr_ctr != CTR_STRONG_LOW) begin
                wr_ctr_next = wr_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**GH_WIDTH; i++) begin
                ctr_mem[i] <= CTR_WEAK_LOW;
            end
        end else if (train_en) begin
            ctr_mem[wr_idx] <= wr_ctr_next;
        end
    end

endmodule

// ==== source/direction_select.sv ====
`timescale 1ns/1ps

module direction_select (
    input  bp_pkg::br_kind_e  query_kind,
    input  bp_pkg::br_kind_e  resolve_kind,
    input  bp_pkg::bank_bit_t rd_bit,
    output logic              train_en,
    output logic              taken_pdc,
    output logic              choice_b_g
);
    import bp_pkg::*;

    logic dir_bit;

    // ------------------------------
    // Training decode
    // ------------------------------

    // Only conditional style jumps carry a useful direction
    always_comb begin
        case (resolve_kind)
            DIRECT_JUMP,
            INDIRECT_JUMP,
            OTHER_JUMP:    train_en = 1'b1;
            default:       train_en = 1'b0;
        endcase
    end

    // ------------------------------
    // Query side
    // ------------------------------

    // Chooser MSB set means trust the global table
    assign choice_b_g = rd_bit[BANK_CHO];
    assign dir_bit    = choice_b_g ? rd_bit[BANK_GLB] : rd_bit[BANK_BIM];

    always_comb begin
        case (query_kind)
            NOT_JUMP:      taken_pdc = 1'b0;
            CALL,
            RET:           taken_pdc = 1'b1;
            DIRECT_JUMP,
            INDIRECT_JUMP,
            OTHER_JUMP:    taken_pdc = dir_bit;
            // Encodings 6 and 7 are not branches
            default:       taken_pdc = 1'b0;
        endcase
    end

endmodule

// ==== source/aim_predictor.sv ====
`timescale 1ns/1ps

module aim_predictor (
    input  logic                clk,
    input  logic                rst_n,
    input  bp_pkg::pdc_query_t  query,
    input  bp_pkg::ex_resolve_t resolve,
    output logic                taken_pdc,
    output logic                choice_b_g
);
    import bp_pkg::*;

    bank_idx_t rd_idx;
    bank_idx_t wr_idx;
    bank_bit_t rd_bit;
    bank_bit_t train_bit;
    logic      train_en;

    // ------------------------------
    // History and index hashing
    // ------------------------------

    history_hash u_history_hash (
        .clk        (clk),
        .rst_n      (rst_n),
        .query_pc   (query.pc),
        .resolve_pc (resolve.pc),
        .train_en   (train_en),
        .taken_real (resolve.taken_real),
        .rd_idx     (rd_idx),
        .wr_idx     (wr_idx)
    );

    // ------------------------------
    // Counter banks
    // ------------------------------

    // Direction banks learn the outcome, the chooser learns which side was right
    assign train_bit[BANK_BIM] = resolve.taken_real;
    assign train_bit[BANK_GLB] = resolve.taken_real;
    assign train_bit[BANK_CHO] = resolve.choice_real;

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        pht_bank u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .rd_idx    (rd_idx[k]),
            .wr_idx    (wr_idx[k]),
            .train_en  (train_en),
            .train_bit (train_bit[k]),
            .rd_bit    (rd_bit[k])
        );
    end

    // ------------------------------
    // Output selection
    // ------------------------------

    direction_select u_direction_select (
        .query_kind   (query.kind),
        .resolve_kind (resolve.kind),
        .rd_bit       (rd_bit),
        .train_en     (train_en),
        .taken_pdc    (taken_pdc),
        .choice_b_g   (choice_b_g)
    );

endmodule

// ==== tb/aim_predictor_checker.sv ====
`timescale 1ns/1ps

module aim_predictor_checker #(
    parameter int SAMPLE_DELAY = 9
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  logic       done,
    input  logic [7:0] group_id,
    input  logic       taken_pdc,
    input  logic       choice_b_g,
    input  logic       exp_taken,
    input  logic       exp_choice,
    output int         checks,
    output int         errors
);
    int   row;
    int   group_checks;
    int   group_errors;
    logic group_open;
    logic [7:0] cur_group;

    initial begin
        checks       = 0;
        errors       = 0;
        row          = 0;
        group_checks = 0;
        group_errors = 0;
        group_open   = 1'b0;
        cur_group    = '0;
    end

    task automatic close_group();
        if (group_open) begin
            $display("Group %0d finished: %0d checks, %0d errors",
                     cur_group, group_checks, group_errors);
        end
        group_checks = 0;
        group_errors = 0;
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        group_checks++;
        if (got !== exp) begin
            errors++;
            group_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h (group %0d, row %0d)",
                     name, got, exp, group_id, row);
        end
    endtask

    // ------------------------------
    // Sampling
    // ------------------------------

    // Outputs settle well before the rising edge, the inputs change on the falling one
    always begin
        @(negedge clk);
        #(SAMPLE_DELAY);
        if (rst_n && valid) begin
            if (!group_open || group_id != cur_group) begin
                close_group();
                cur_group  = group_id;
                group_open = 1'b1;
            end
            row++;
            compare_bit("taken_pdc", taken_pdc, exp_taken);
            compare_bit("choice_b_g", choice_b_g, exp_choice);
        end
    end

    always @(posedge done) begin
        close_group();
        group_open = 1'b0;
    end

endmodule

// ==== tb/aim_predictor_tb.sv ====
`timescale 1ns/1ps

module aim_predictor_tb;
    import bp_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 100;
    localparam int MAX_LINES     = 2000;

    logic        clk;
    logic        rst_n;
    pdc_query_t  query;
    ex_resolve_t resolve;
    logic        taken_pdc;
    logic        choice_b_g;

    logic        exp_valid;
    logic        exp_taken;
    logic        exp_choice;
    logic [7:0]  exp_group;
    logic        run_done;

    int check_count;
    int check_errors;
    int format_errors;

    // ------------------------------
    // Clock, DUT and checker
    // ------------------------------

    always #(CLK_PERIOD / 2) clk = ~clk;

    aim_predictor u_aim_predictor (
        .clk        (clk),
        .rst_n      (rst_n),
        .query      (query),
        .resolve    (resolve),
        .taken_pdc  (taken_pdc),
        .choice_b_g (choice_b_g)
    );

    aim_predictor_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (exp_valid),
        .done       (run_done),
        .group_id   (exp_group),
        .taken_pdc  (taken_pdc),
        .choice_b_g (choice_b_g),
        .exp_taken  (exp_taken),
        .exp_choice (exp_choice),
        .checks     (check_count),
        .errors     (check_errors)
    );

    task automatic drive_idle();
        query      = '0;
        resolve    = '0;
        exp_valid  = 1'b0;
        exp_taken  = 1'b0;
        exp_choice = 1'b0;
    endtask

    function automatic logic is_blank_or_comment(input string line);
        if (line.len() == 0) begin
            return 1'b1;
        end
        return (line.getc(0) == "#" || line.getc(0) == "\n" || line.getc(0) == "\r");
    endfunction

    // ------------------------------
    // Reset
    // ------------------------------

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int          fd;
        int          fields;
        int          lines;
        int          wait_cycles;
        string       line;
        logic [31:0] grp;
        logic [31:0] qpc;
        logic [31:0] qkind;
        logic [31:0] rpc;
        logic [31:0] rkind;
        logic [31:0] tr;
        logic [31:0] cr;
        logic [31:0] et;
        logic [31:0] ec;

        exp_group     = '0;
        run_done      = 1'b0;
        format_errors = 0;
        drive_idle();

        fd = $fopen("tb/aim_predictor_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file tb/aim_predictor_golden.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            wait_cycles = 0;
            while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
                @(posedge clk);
                wait_cycles++;
            end

            if (rst_n !== 1'b1) begin
                $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
                $display("Done: errors found");
                $finish;
            end else begin
                // One golden row per falling edge
                lines = 0;
                while (!$feof(fd) && lines < MAX_LINES) begin
                    lines++;
                    line = "";
                    void'($fgets(line, fd));
                    if (!is_blank_or_comment(line)) begin
                        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                         grp, qpc, qkind, rpc, rkind, tr, cr, et, ec);
                        if (fields != 9) begin
                            format_errors++;
                            $display("Golden line %0d has %0d fields instead of 9",
                                     lines, fields);
                        end else begin
                            @(negedge clk);
                            query.pc            = addr_t'(qpc);
                            query.kind          = br_kind_e'(qkind[2:0]);
                            resolve.pc          = addr_t'(rpc);
                            resolve.kind        = br_kind_e'(rkind[2:0]);
                            resolve.taken_real  = tr[0];
                            resolve.choice_real = cr[0];
                            exp_group           = grp[7:0];
                            exp_taken           = et[0];
                            exp_choice          = ec[0];
                            exp_valid           = 1'b1;
                        end
                    end
                end

                if (!$feof(fd)) begin
                    $display("Golden file did not end within %0d lines", MAX_LINES);
                    $display("Done: errors found");
                    $finish;
                end else begin
                    $fclose(fd);

                    @(negedge clk);
                    drive_idle();
                    @(negedge clk);
                    run_done = 1'b1;
                    #1;

                    $display("Checks: %0d, check errors: %0d, golden format errors: %0d",
                             check_count, check_errors, format_errors);
                    if (check_errors == 0 && format_errors == 0 && check_count > 0) begin
                        $display("Done: no errors");
                    end else begin
                        $display("Done: errors found");
                    end
                    $finish;
                end
            end
        end
    end

endmodule

// ==== tb/aim_predictor_golden.txt ====
# grp qpc qkind rpc rkind taken_real choice_real exp_taken_pdc exp_choice_b_g
# All hex, one row per cycle, kinds 0 NOT_JUMP 1 DIRECT 2 CALL 3 RET 4 INDIRECT 5 OTHER
1 00000000 1 00000000 0 0 0 0 0
1 01234567 4 00000000 0 0 0 0 0
1 1fffffff 5 00000000 0 0 0 0 0
1 00abcdef 1 00000000 0 0 0 0 0
2 00000100 0 00000000 0 0 0 0 0
2 00000100 2 00000000 0 0 0 1 0
2 00000100 3 00000000 0 0 0 1 0
2 00000100 6 00000000 0 0 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000000 0 00000040 1 1 0 0 0
3 00000040 1 00000000 0 0 0 0 0
3 00000040 1 00000040 1 1 0 0 0
3 00000040 1 00000040 1 1 0 1 0
3 00000040 1 00000000 0 0 0 1 0
3 00000040 1 00000040 1 1 0 1 0
3 000003bf 1 000003bf 1 0 0 1 0
3 000003bf 1 000003bf 1 0 0 1 0
3 000003bf 1 00000000 0 0 0 0 0
4 000003bf 1 000003bf 2 1 1 0 0
4 000003bf 1 000003bf 3 1 1 0 0
4 000003bf 1 000003bf 0 1 1 0 0
4 000003bf 1 00000000 0 0 0 0 0
4 00000040 3 00000000 0 0 0 1 0
4 00000040 0 00000000 0 0 0 0 0
5 00000000 0 00000123 1 1 0 0 0
5 00000000 0 00000123 1 0 0 0 0
5 00000000 0 00000123 1 1 0 0 0
5 00000000 0 00000123 1 0 0 0 0
5 00000000 0 00000123 1 1 0 0 0
5 00000000 0 00000123 1 0 0 0 0
5 00000000 0 00000123 1 1 0 0 0
5 00000000 0 00000123 1 0 0 0 0
5 00000000 0 00000123 1 1 0 0 0
5 00000000 0 00000123 1 0 0 0 0
5 00000123 1 00000123 1 1 1 0 0
5 00000123 1 00000123 1 0 1 0 0
5 00000123 1 00000123 1 1 1 1 1
5 00000123 1 00000123 1 0 1 0 0
5 00000123 1 00000000 0 0 0 1 1
5 00000123 4 00000000 0 0 0 1 1
5 00000123 2 00000000 0 0 0 1 1
5 00000123 0 00000000 0 0 0 0 1
5 00000123 5 00000123 1 1 1 1 1
5 00000123 1 00000000 0 0 0 0 1
6 00000000 0 000003be 1 1 0 0 0
6 000003bf 1 000003be 1 1 0 0 0
6 000003bf 1 00000000 0 0 0 1 0

// ==== vlog.f ====
source/bp_pkg.sv
source/history_hash.sv
source/pht_bank.sv
source/direction_select.sv
source/aim_predictor.sv
tb/aim_predictor_checker.sv
tb/aim_predictor_tb.sv
